/* include/lcd_consts.svh */
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// Clock cycles in one enable period
`define LCD_CLK_DIV 24000

// Enable periods spent in the power-on wait
`define LCD_DELAY_PERIODS 10

// Characters per display row
`define LCD_ROW_LEN 16

`endif

/* source/lcd_bus_pkg.sv */
`default_nettype none

package lcd_bus_pkg;

    // Pins of the HD44780 parallel bus in 8-bit mode
    typedef struct packed {
        logic       en;
        logic       rw;   // Tied low, no readback
        logic       rs;   // 0 command, 1 character
        logic [7:0] data;
    } lcd_pins_t;

    // Sequencer steps
    typedef enum logic [2:0] {
        idle,
        set_function,
        disp_off,
        disp_clear,
        entry_mode,
        disp_on,
        row_addr,     // Row selected by the sequencer's row bit
        row_char      // Column selected by the column counter
    } seq_step_t;

    // Command bytes from the HD44780 datasheet
    localparam logic [7:0] cmd_function_set = 8'h38; // 8-bit, 2 lines, 5x7
    localparam logic [7:0] cmd_disp_off     = 8'h08;
    localparam logic [7:0] cmd_disp_clear   = 8'h01;
    localparam logic [7:0] cmd_entry_mode   = 8'h06; // Increment, no shift
    localparam logic [7:0] cmd_disp_on      = 8'h0C; // Cursor off
    localparam logic [7:0] cmd_row1_addr    = 8'h80;
    localparam logic [7:0] cmd_row2_addr    = 8'hC0;

endpackage

`default_nettype wire

/* source/text_pkg.sv */
`default_nettype none

`include "lcd_consts.svh"

package text_pkg;

    typedef logic [7:0] char_t; // ASCII

    // Column 0 sits in the top byte, leftmost on the display
    typedef char_t [0:`LCD_ROW_LEN-1] row_t;

    typedef struct packed {
        row_t row_1;
        row_t row_2;
    } screen_t;

    // Single character write from the host, valid is a one-cycle strobe
    typedef struct packed {
        logic                            valid;
        logic                            row;  // 0 top, 1 bottom
        logic [$clog2(`LCD_ROW_LEN)-1:0] col;
        char_t                           ch;
    } text_wr_t;

endpackage

`default_nettype wire

/* source/text_buffer.sv */
`default_nettype none

`include "lcd_consts.svh"

module text_buffer (
    input  wire                clk,
    input  wire                rst,
    input  wire text_pkg::text_wr_t text_wr,
    output text_pkg::screen_t  screen
);

    localparam text_pkg::char_t blank = 8'h20;

    // Whole screen lives in flops so the sequencer can pick any cell
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `LCD_ROW_LEN; i++) begin
                screen.row_1[i] <= blank;
                screen.row_2[i] <= blank;
            end
        end else if (text_wr.valid) begin
            if (text_wr.row)
                screen.row_2[text_wr.col] <= text_wr.ch;
            else
                screen.row_1[text_wr.col] <= text_wr.ch;
        end
    end

endmodule

`default_nettype wire

/* source/lcd_strobe_gen.sv */
`default_nettype none

`include "lcd_consts.svh"

module lcd_strobe_gen #(
    parameter int clk_div = `LCD_CLK_DIV
) (
    input  wire  clk,
    input  wire  rst,
    output logic en,
    output logic step
);

    localparam int delay_len = clk_div * `LCD_DELAY_PERIODS;
    localparam int delay_w   = $clog2(delay_len);
    localparam int period_w  = $clog2(clk_div);

    localparam logic [delay_w-1:0]  delay_last  = delay_w'(delay_len - 1);
    localparam logic [period_w-1:0] period_last = period_w'(clk_div - 1);
    localparam logic [period_w-1:0] period_half = period_w'((clk_div - 1) / 2);

    logic [delay_w-1:0]  delay_cnt;
    logic [period_w-1:0] period_cnt;
    logic                delay_done;

    assign delay_done = (delay_cnt == delay_last);

    // Power-on wait, counts once and parks at the last value
    always_ff @(posedge clk) begin
        if (!rst)
            delay_cnt <= '0;
        else if (!delay_done)
            delay_cnt <= delay_cnt + 1'b1;
    end

    // Enable period divider, held at zero until the wait is over
    always_ff @(posedge clk) begin
        if (!rst) begin
            period_cnt <= '0;
        end else if (delay_done) begin
            if (period_cnt == period_last)
                period_cnt <= '0;
            else
                period_cnt <= period_cnt + 1'b1;
        end else begin
            period_cnt <= '0;
        end
    end

    // High for the first half, so en also sits high during the wait
    assign en   = (period_cnt <= period_half);
    assign step = (period_cnt == period_last); // Last cycle of the period

endmodule

`default_nettype wire

/* source/lcd_sequencer.sv */
`default_nettype none

`include "lcd_consts.svh"

module lcd_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     step,
    input  wire text_pkg::screen_t  screen,
    output logic                    rs,
    output text_pkg::char_t         data
);

    localparam int col_w = $clog2(`LCD_ROW_LEN);
    localparam logic [col_w-1:0] last_col = col_w'(`LCD_ROW_LEN - 1);

    lcd_bus_pkg::seq_step_t state;
    lcd_bus_pkg::seq_step_t next_state;
    logic                   row;
    logic                   next_row;
    logic [col_w-1:0]       col;
    logic [col_w-1:0]       next_col;
    text_pkg::char_t        next_data;

    // Step, row and column that follow the current transfer
    always_comb begin
        next_state = state;
        next_row   = row;
        next_col   = col;
        case (state)
            lcd_bus_pkg::idle:         next_state = lcd_bus_pkg::set_function;
            lcd_bus_pkg::set_function: next_state = lcd_bus_pkg::disp_off;
            lcd_bus_pkg::disp_off:     next_state = lcd_bus_pkg::disp_clear;
            lcd_bus_pkg::disp_clear:   next_state = lcd_bus_pkg::entry_mode;
            lcd_bus_pkg::entry_mode:   next_state = lcd_bus_pkg::disp_on;
            lcd_bus_pkg::disp_on: begin
                next_state = lcd_bus_pkg::row_addr;
                next_row   = 1'b0;
            end
            lcd_bus_pkg::row_addr: begin
                next_state = lcd_bus_pkg::row_char;
                next_col   = '0;
            end
            lcd_bus_pkg::row_char: begin
                if (col == last_col) begin
                    // End of a row, move to the other one and never back to init
                    next_state = lcd_bus_pkg::row_addr;
                    next_row   = ~row;
                end else begin
                    next_col = col + 1'b1;
                end
            end
            default: next_state = lcd_bus_pkg::idle;
        endcase
    end

    // Byte that belongs to the next step
    always_comb begin
        case (next_state)
            lcd_bus_pkg::set_function: next_data = lcd_bus_pkg::cmd_function_set;
            lcd_bus_pkg::disp_off:     next_data = lcd_bus_pkg::cmd_disp_off;
            lcd_bus_pkg::disp_clear:   next_data = lcd_bus_pkg::cmd_disp_clear;
            lcd_bus_pkg::entry_mode:   next_data = lcd_bus_pkg::cmd_entry_mode;
            lcd_bus_pkg::disp_on:      next_data = lcd_bus_pkg::cmd_disp_on;
            lcd_bus_pkg::row_addr: begin
                if (next_row)
                    next_data = lcd_bus_pkg::cmd_row2_addr;
                else
                    next_data = lcd_bus_pkg::cmd_row1_addr;
            end
            lcd_bus_pkg::row_char: begin
                // Screen is sampled here, at the step cycle
                if (next_row)
                    next_data = screen.row_2[next_col];
                else
                    next_data = screen.row_1[next_col];
            end
            default:                   next_data = data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= lcd_bus_pkg::idle;
            row   <= 1'b0;
            col   <= '0;
        end else if (step) begin
            state <= next_state;
            row   <= next_row;
            col   <= next_col;
        end
    end

    // New value shows up as en rises, LCD latches it on the falling edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            rs   <= 1'b0;
            data <= 8'h00;
        end else if (step) begin
            rs   <= (next_state == lcd_bus_pkg::row_char); // Characters only
            data <= next_data;
        end
    end

endmodule

`default_nettype wire

/* source/lcd_display_top.sv */
`default_nettype none

`include "lcd_consts.svh"

module lcd_display_top #(
    parameter int clk_div = `LCD_CLK_DIV
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire text_pkg::text_wr_t text_wr,
    output lcd_bus_pkg::lcd_pins_t  lcd
);

    text_pkg::screen_t screen;
    text_pkg::char_t   data;
    logic              en;
    logic              step;
    logic              rs;

    text_buffer u_text_buffer (
        .clk     (clk),
        .rst     (rst),
        .text_wr (text_wr),
        .screen  (screen)
    );

    lcd_strobe_gen #(
        .clk_div (clk_div)
    ) u_lcd_strobe_gen (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .step (step)
    );

    lcd_sequencer u_lcd_sequencer (
        .clk    (clk),
        .rst    (rst),
        .step   (step),
        .screen (screen),
        .rs     (rs),
        .data   (data)
    );

    // Write-only bus, rw stays low
    assign lcd = '{en: en, rw: 1'b0, rs: rs, data: data};

endmodule

`default_nettype wire

/* test/lcd_bus_monitor.sv */
`default_nettype none

module lcd_bus_monitor (
    input wire                         clk,
    input wire                         rst,
    input wire lcd_bus_pkg::lcd_pins_t lcd
);

    timeunit 1ns;
    timeprecision 100ps;

    lcd_bus_pkg::lcd_pins_t xfers[$]; // Popped by the tests
    int   rw_errors   = 0;
    int   first_cycle = -1;           // Cycles from reset release to the first capture
    int   cycle       = 0;
    logic rst_q       = 1'b0;
    logic en_q        = 1'b1;
    logic armed       = 1'b0;

    // Reset level as the DUT saw it at the last rising edge
    always @(posedge clk) begin
        rst_q <= rst;
    end

    // Bus is sampled mid-cycle between register updates
    always @(negedge clk) begin
        if (!rst_q) begin
            xfers.delete();
            armed       = 1'b0;
            cycle       = 0;
            first_cycle = -1;
        end else begin
            cycle++;
            if (lcd.en && !en_q) begin
                // First rise after the wait carries a real byte
                armed = 1'b1;
            end else if (!lcd.en && en_q && armed) begin
                xfers.push_back(lcd); // LCD latches here
                if (first_cycle < 0)
                    first_cycle = cycle;
            end
        end

        if (lcd.rw !== 1'b0) begin
            $display("mismatch at %0t ns: lcd.rw expected 0 got %b", $time, lcd.rw);
            rw_errors++;
        end
        en_q = lcd.en;
    end

endmodule

`default_nettype wire

/* test/lcd_display_tb.sv */
`default_nettype none

`include "lcd_consts.svh"

module lcd_display_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_div      = 8;
    localparam int reset_cycles = 16;
    localparam int col_w        = $clog2(`LCD_ROW_LEN);
    localparam int delay_cycles = clk_div * `LCD_DELAY_PERIODS;
    localparam int frame_xfers  = 5 + 2 * (1 + `LCD_ROW_LEN); // Init plus two rows
    // Two resets with their waits, six frames, some slack
    localparam int cycle_limit  = 2 * (reset_cycles + delay_cycles)
                                + 6 * frame_xfers * clk_div + 200;

    logic                   clk     = 1'b0;
    logic                   rst     = 1'b0;
    text_pkg::text_wr_t     text_wr = '0;
    lcd_bus_pkg::lcd_pins_t lcd;

    text_pkg::screen_t shadow; // What the display should show
    integer            seed   = 32'hbe4b2928;
    int                errors = 0;
    int                checks = 0;
    int                tests  = 0;
    int                cycles = 0;

    always #4 clk = ~clk;

    lcd_display_top #(
        .clk_div (clk_div)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .text_wr (text_wr),
        .lcd     (lcd)
    );

    lcd_bus_monitor mon (
        .clk (clk),
        .rst (rst),
        .lcd (lcd)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic text_pkg::row_t blank_row();
        text_pkg::row_t r;
        for (int i = 0; i < `LCD_ROW_LEN; i++)
            r[i] = 8'h20;
        return r;
    endfunction

    // Printable ASCII without the space, so it never looks like a blank cell
    function automatic text_pkg::char_t random_char();
        return 8'(33 + ({$random(seed)} % 94));
    endfunction

    task automatic check_rs(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %b got %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_char(input string name, input text_pkg::char_t expected,
                              input text_pkg::char_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst     = 1'b0;
        text_wr = '0;
        repeat (reset_cycles) @(negedge clk);
        rst          = 1'b1;
        shadow.row_1 = blank_row();
        shadow.row_2 = blank_row();
    endtask

    task automatic write_char(input logic row, input int col, input text_pkg::char_t ch);
        @(negedge clk);
        text_wr = '{valid: 1'b1, row: row, col: col_w'(col), ch: ch};
        @(negedge clk);
        text_wr.valid = 1'b0;
        if (row)
            shadow.row_2[col] = ch;
        else
            shadow.row_1[col] = ch;
    endtask

    // Reads are done on the rising edge, the monitor pushes on the falling one
    task automatic pop_xfer(output lcd_bus_pkg::lcd_pins_t xfer);
        @(posedge clk);
        while (mon.xfers.size() == 0)
            @(posedge clk);
        xfer = mon.xfers.pop_front();
    endtask

    task automatic expect_xfer(input string what, input logic exp_rs,
                               input text_pkg::char_t exp_data);
        lcd_bus_pkg::lcd_pins_t xfer;
        pop_xfer(xfer);
        check_rs($sformatf("lcd.rs (%s)", what), exp_rs, xfer.rs);
        check_char($sformatf("lcd.data (%s)", what), exp_data, xfer.data);
    endtask

    task automatic expect_row(input int row, input text_pkg::row_t exp);
        for (int c = 0; c < `LCD_ROW_LEN; c++)
            expect_xfer($sformatf("row %0d col %0d", row + 1, c), 1'b1, exp[c]);
    endtask

    task automatic expect_init();
        expect_xfer("function set", 1'b0, 8'h38);
        expect_xfer("display off", 1'b0, 8'h08);
        expect_xfer("clear", 1'b0, 8'h01);
        expect_xfer("entry mode", 1'b0, 8'h06);
        expect_xfer("display on", 1'b0, 8'h0C);
        expect_xfer("row 1 address", 1'b0, 8'h80);
    endtask

    task automatic check_start_delay();
        checks++;
        if (mon.first_cycle <= delay_cycles) begin
            errors++;
            $display("first transfer came %0d cycles after reset, inside the power-on wait",
                     mon.first_cycle);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    task automatic test_init();
        int start_errors;
        start_errors = errors;
        // Text goes in during the power-on wait
        for (int c = 0; c < `LCD_ROW_LEN; c++)
            write_char(1'b0, c, random_char());
        for (int c = 0; c < 12; c++)
            write_char(1'b1, c, random_char()); // Columns 12 to 15 stay blank
        @(posedge clk);
        checks++;
        if (mon.xfers.size() != 0) begin
            errors++;
            $display("transfers were captured while the power-on wait was running");
        end
        expect_init();
        check_start_delay();
        finish_test("init", start_errors);
    endtask

    task automatic test_row1();
        int start_errors;
        start_errors = errors;
        expect_row(0, shadow.row_1);
        finish_test("row1", start_errors);
    endtask

    task automatic test_row2_wrap();
        int start_errors;
        start_errors = errors;
        expect_xfer("row 2 address", 1'b0, 8'hC0);
        expect_row(1, shadow.row_2);
        expect_xfer("wrap to row 1", 1'b0, 8'h80); // Not back to function set
        finish_test("row2_wrap", start_errors);
    endtask

    task automatic test_update();
        int                start_errors;
        text_pkg::screen_t frame;
        text_pkg::char_t   ch;
        start_errors = errors;
        frame        = shadow;
        for (int c = 0; c < 8; c++)
            expect_xfer($sformatf("row 1 col %0d", c), 1'b1, frame.row_1[c]);

        // Cells behind the cursor change now and show up one frame later
        do
            ch = random_char();
        while (ch == shadow.row_1[2]);
        write_char(1'b0, 2, ch);
        do
            ch = random_char();
        while (ch == shadow.row_1[5]);
        write_char(1'b0, 5, ch);

        for (int c = 8; c < `LCD_ROW_LEN; c++)
            expect_xfer($sformatf("row 1 col %0d", c), 1'b1, frame.row_1[c]);
        expect_xfer("row 2 address", 1'b0, 8'hC0);
        expect_row(1, frame.row_2);
        expect_xfer("row 1 address", 1'b0, 8'h80);
        expect_row(0, shadow.row_1);
        expect_xfer("row 2 address", 1'b0, 8'hC0);
        expect_row(1, shadow.row_2);
        finish_test("update", start_errors);
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        reset_dut();
        expect_init();
        check_start_delay();
        expect_row(0, blank_row());
        expect_xfer("row 2 address", 1'b0, 8'hC0);
        expect_row(1, blank_row());
        finish_test("reset", start_errors);
    endtask

    initial begin
        reset_dut();
        test_init();
        test_row1();
        test_row2_wrap();
        test_update();
        test_reset();
        $display("tests %0d, checks %0d, errors %0d",
                 tests, checks, errors + mon.rw_errors);
        if (errors + mon.rw_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* lcd_display.f */
+incdir+include
source/lcd_bus_pkg.sv
source/text_pkg.sv
source/text_buffer.sv
source/lcd_strobe_gen.sv
source/lcd_sequencer.sv
source/lcd_display_top.sv
test/lcd_bus_monitor.sv
test/lcd_display_tb.sv
